//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_core
FLAGS     ?=
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLAGS FILELIST OBJ_DIR"

test:
	$(VERILATOR) --binary --timescale 1ns/1ns $(FLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "Test passed"

clean:
	rm -rf $(OBJ_DIR)

//--- alu.sv
`timescale 1ns/1ns

module alu import core_pkg::*; (
    core_dec_if.exe exe,
    output word_t   result_o
);

    logic [4:0] shamt;
    word_t      sum;

    assign shamt = exe.op2[4:0];
    assign sum   = exe.op1 + exe.op2;   // shared by add, loads, stores, jumps

    always_comb begin
        case (exe.alu_fn)
            ALU_ADD:  result_o = sum;
            ALU_SUB:  result_o = exe.op1 - exe.op2;
            ALU_AND:  result_o = exe.op1 & exe.op2;
            ALU_OR:   result_o = exe.op1 | exe.op2;
            ALU_XOR:  result_o = exe.op1 ^ exe.op2;
            ALU_SLL:  result_o = exe.op1 << shamt;
            ALU_SRL:  result_o = exe.op1 >> shamt;
            ALU_SRA:  result_o = $signed(exe.op1) >>> shamt;
            ALU_SLT:  result_o = word_t'($signed(exe.op1) < $signed(exe.op2));
            ALU_SLTU: result_o = word_t'(exe.op1 < exe.op2);
            ALU_JALR: result_o = sum & ~word_t'(1);   // target is half-word aligned
            default:  result_o = sum;
        endcase
    end

endmodule

//--- branch_unit.sv
`timescale 1ns/1ns

module branch_unit import core_pkg::*; (
    core_dec_if.exe exe,
    input  word_t   pc_i,
    output logic    taken_o,
    output word_t   target_o
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = exe.op1 == exe.op2;
    assign lt_s = $signed(exe.op1) < $signed(exe.op2);
    assign lt_u = exe.op1 < exe.op2;

    always_comb begin
        case (exe.br_fn)
            BR_BEQ:  taken_o = eq;
            BR_BNE:  taken_o = !eq;
            BR_BLT:  taken_o = lt_s;
            BR_BGE:  taken_o = !lt_s;
            BR_BLTU: taken_o = lt_u;
            BR_BGEU: taken_o = !lt_u;
            default: taken_o = 1'b0;    // not a branch
        endcase
    end

    assign target_o = pc_i + exe.br_offset;

endmodule

//--- core.sv
`timescale 1ns/1ns

module core import core_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    output word_t imem_addr_o,
    input  word_t imem_inst_i,
    output word_t dmem_addr_o,
    input  word_t dmem_rdata_i,
    output logic  dmem_wen_o,
    output word_t dmem_wdata_o,
    output word_t gp_o,
    output logic  exit_o
);

    word_t     pc;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     alu_result;
    logic      br_taken;
    word_t     br_target;
    logic      rf_we;
    reg_addr_t rd_addr;
    word_t     rd_data;

    core_dec_if dec_bus ();

    assign imem_addr_o = pc;
    assign dmem_addr_o = alu_result;    // effective address for lw / sw

    inst_decoder u_decoder (
        .inst_i       (imem_inst_i),
        .pc_i         (pc),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .dmem_wen_o   (dmem_wen_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dec          (dec_bus.dec)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (rf_we),
        .rd_addr_i  (rd_addr),
        .rd_data_i  (rd_data),
        .gp_o       (gp_o)
    );

    alu u_alu (
        .exe      (dec_bus.exe),
        .result_o (alu_result)
    );

    branch_unit u_branch (
        .exe      (dec_bus.exe),
        .pc_i     (pc),
        .taken_o  (br_taken),
        .target_o (br_target)
    );

    retire_unit u_retire (
        .clk          (clk),
        .rst_n        (rst_n),
        .ret          (dec_bus.ret),
        .alu_result_i (alu_result),
        .br_taken_i   (br_taken),
        .br_target_i  (br_target),
        .dmem_rdata_i (dmem_rdata_i),
        .pc_o         (pc),
        .exit_o       (exit_o),
        .rf_we_o      (rf_we),
        .rd_addr_o    (rd_addr),
        .rd_data_o    (rd_data)
    );

endmodule

//--- core_dec_if.sv
`timescale 1ns/1ns

interface core_dec_if import core_pkg::*; ();

    word_t     op1;
    word_t     op2;
    alu_fn_e   alu_fn;
    br_fn_e    br_fn;
    word_t     br_offset;   // B-type immediate
    logic      jump;        // jal / jalr
    logic      rf_wen;
    reg_addr_t rd_addr;
    wb_sel_e   wb_sel;

    modport dec (
        output op1, op2, alu_fn, br_fn, br_offset,
        output jump, rf_wen, rd_addr, wb_sel
    );

    // alu and branch unit
    modport exe (
        input op1, op2, alu_fn, br_fn, br_offset
    );

    modport ret (
        input jump, rf_wen, rd_addr, wb_sel
    );

endinterface

//--- core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath width
`define CORE_XLEN       32

// architectural register file
`define CORE_NREGS      32
`define CORE_RADDR_W    5

// fetch from this address stops the core
`define CORE_EXIT_ADDR  32'h44

// register mirrored on gp_o (x3)
`define CORE_GP_REG     3

`endif

//--- core_pkg.sv
`include "core_defs.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0]    word_t;
    typedef logic [`CORE_RADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_JALR = 4'd10    // add, then clear bit 0
    } alu_fn_e;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_BEQ  = 3'd1,
        BR_BNE  = 3'd2,
        BR_BLT  = 3'd3,
        BR_BGE  = 3'd4,
        BR_BLTU = 3'd5,
        BR_BGEU = 3'd6
    } br_fn_e;

    // writeback source
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC4 = 2'd2
    } wb_sel_e;

endpackage

//--- inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder import core_pkg::*; (
    input  word_t     inst_i,
    input  word_t     pc_i,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    output logic      dmem_wen_o,
    output word_t     dmem_wdata_o,
    core_dec_if.dec   dec
);

    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;
    localparam logic [2:0] F3_WORD = 3'b010;       // lw / sw

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;
    logic       op_ok;
    logic       imm_ok;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_j;
    word_t      imm_u;

    function automatic alu_fn_e arith_fn(input logic [2:0] f3, input logic sel_alt);
        alu_fn_e fn;
        case (f3)
            3'b000:  fn = sel_alt ? ALU_SUB : ALU_ADD;
            3'b001:  fn = ALU_SLL;
            3'b010:  fn = ALU_SLT;
            3'b011:  fn = ALU_SLTU;
            3'b100:  fn = ALU_XOR;
            3'b101:  fn = sel_alt ? ALU_SRA : ALU_SRL;
            3'b110:  fn = ALU_OR;
            default: fn = ALU_AND;
        endcase
        return fn;
    endfunction

    function automatic br_fn_e cond_fn(input logic [2:0] f3);
        br_fn_e fn;
        case (f3)
            3'b000:  fn = BR_BEQ;
            3'b001:  fn = BR_BNE;
            3'b100:  fn = BR_BLT;
            3'b101:  fn = BR_BGE;
            3'b110:  fn = BR_BLTU;
            3'b111:  fn = BR_BGEU;
            default: fn = BR_NONE;
        endcase
        return fn;
    endfunction

    assign opcode     = inst_i[6:0];
    assign funct3     = inst_i[14:12];
    assign funct7     = inst_i[31:25];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};

    // only sub and sra use the alternate funct7
    assign alt    = funct7 == F7_ALT;
    assign op_ok  = (funct7 == F7_BASE) || (alt && (funct3 == 3'b000 || funct3 == 3'b101));
    assign imm_ok = (funct3 == 3'b001) ? (funct7 == F7_BASE) :
                    (funct3 == 3'b101) ? (funct7 == F7_BASE || alt) : 1'b1;

    assign dec.br_offset = imm_b;
    assign dec.rd_addr   = inst_i[11:7];
    assign dmem_wdata_o  = rs2_data_i;

    always_comb begin
        // defaults are a harmless nop
        dec.op1    = rs1_data_i;
        dec.op2    = rs2_data_i;
        dec.alu_fn = ALU_ADD;
        dec.br_fn  = BR_NONE;
        dec.jump   = 1'b0;
        dec.rf_wen = 1'b0;
        dec.wb_sel = WB_ALU;
        dmem_wen_o = 1'b0;
        case (opcode)
            OPC_OP: begin
                dec.alu_fn = arith_fn(funct3, alt);
                dec.rf_wen = op_ok;
            end
            OPC_OP_IMM: begin
                dec.op2    = imm_i;
                dec.alu_fn = arith_fn(funct3, alt && funct3 == 3'b101);
                dec.rf_wen = imm_ok;
            end
            OPC_LOAD: begin
                dec.op2    = imm_i;
                dec.wb_sel = WB_MEM;
                dec.rf_wen = funct3 == F3_WORD;
            end
            OPC_STORE: begin
                dec.op2    = imm_s;
                dmem_wen_o = funct3 == F3_WORD;
            end
            OPC_BRANCH: dec.br_fn = cond_fn(funct3);   // bad funct3 gives BR_NONE
            OPC_JAL: begin
                dec.op1    = pc_i;
                dec.op2    = imm_j;
                dec.jump   = 1'b1;
                dec.rf_wen = 1'b1;
                dec.wb_sel = WB_PC4;
            end
            OPC_JALR: begin
                dec.op2    = imm_i;
                dec.alu_fn = ALU_JALR;
                dec.jump   = funct3 == 3'b000;
                dec.rf_wen = funct3 == 3'b000;
                dec.wb_sel = WB_PC4;
            end
            OPC_LUI: begin
                dec.op1    = '0;
                dec.op2    = imm_u;
                dec.rf_wen = 1'b1;
            end
            OPC_AUIPC: begin
                dec.op1    = pc_i;
                dec.op2    = imm_u;
                dec.rf_wen = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- reg_file.sv
`timescale 1ns/1ns
`include "core_defs.svh"

module reg_file import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    output word_t     rs1_data_o,
    output word_t     rs2_data_o,
    input  logic      we_i,
    input  reg_addr_t rd_addr_i,
    input  word_t     rd_data_i,
    output word_t     gp_o
);

    word_t regs [1:`CORE_NREGS-1];  // x0 has no storage

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];
    assign gp_o       = regs[`CORE_GP_REG];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < `CORE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_addr_i != '0) begin   // writes to x0 dropped
            regs[rd_addr_i] <= rd_data_i;
        end
    end

endmodule

//--- retire_unit.sv
`timescale 1ns/1ns
`include "core_defs.svh"

module retire_unit import core_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    core_dec_if.ret   ret,
    input  word_t     alu_result_i,
    input  logic      br_taken_i,
    input  word_t     br_target_i,
    input  word_t     dmem_rdata_i,
    output word_t     pc_o,
    output logic      exit_o,
    output logic      rf_we_o,
    output reg_addr_t rd_addr_o,
    output word_t     rd_data_o
);

    word_t pc_q;
    word_t pc_plus4;
    word_t pc_next;

    assign pc_plus4 = pc_q + word_t'(4);
    assign exit_o   = pc_q == `CORE_EXIT_ADDR;
    assign pc_o     = pc_q;

    // taken branch wins, jumps take the alu target
    assign pc_next = br_taken_i ? br_target_i :
                     ret.jump   ? alu_result_i : pc_plus4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= '0;
        end else if (!exit_o) begin    // hold at exit address
            pc_q <= pc_next;
        end
    end

    always_comb begin
        case (ret.wb_sel)
            WB_MEM:  rd_data_o = dmem_rdata_i;
            WB_PC4:  rd_data_o = pc_plus4;     // link value
            default: rd_data_o = alu_result_i;
        endcase
    end

    assign rf_we_o   = ret.rf_wen && !exit_o;
    assign rd_addr_o = ret.rd_addr;

endmodule

//--- tb_core.sv
`timescale 1ns/1ns

module tb_core import core_pkg::*; ();

    localparam word_t      EXIT_ADDR = 32'h44;
    localparam int         EXIT_IDX  = 17;    // word index of the exit address
    localparam int         MEM_WORDS = 64;
    localparam int         TIMEOUT   = 100;
    localparam word_t      NOP       = 32'h0000_0013;
    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_I      = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;

    logic  clk;
    logic  rst_n;
    logic  dmem_wen;
    logic  exit_flag;
    word_t imem_addr;
    word_t imem_inst;
    word_t dmem_addr;
    word_t dmem_rdata;
    word_t dmem_wdata;
    word_t gp;
    word_t imem [MEM_WORDS];
    word_t dmem [MEM_WORDS];
    word_t store_addr;
    word_t store_data;
    word_t lfsr = 32'h3bc5_a394;
    int    prog_len;
    int    store_cnt;
    int    checks;
    int    errors;

    core core_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_inst_i  (imem_inst),
        .dmem_addr_o  (dmem_addr),
        .dmem_rdata_i (dmem_rdata),
        .dmem_wen_o   (dmem_wen),
        .dmem_wdata_o (dmem_wdata),
        .gp_o         (gp),
        .exit_o       (exit_flag)
    );

    always #50 clk = ~clk;

    // both memories answer in the same cycle
    assign imem_inst  = imem[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    function automatic word_t lfsr_step(word_t s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic word_t rand_bits(int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function automatic word_t sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic word_t enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                    logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_R};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                    logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                    logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic word_t enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    // RV32I branch conditions
    function automatic logic branch_taken(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic finish_run();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic check_val(string sig, string what, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s (%s): got %h expected %h", sig, what, got, exp);
        end
    endtask

    task automatic begin_prog();
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = NOP;
        end
        prog_len  = 0;
        store_cnt = 0;
    endtask

    task automatic emit(word_t inst);
        imem[prog_len] = inst;
        prog_len++;
    endtask

    task automatic load_const(logic [4:0] rd, word_t val);
        logic [19:0] upper;
        upper = val[31:12] + {19'b0, val[11]};   // addi sign-extends the low half
        emit(enc_u(upper, rd, OP_LUI));
        emit(enc_i(val[11:0], rd, 3'b000, rd, OP_I));
    endtask

    task automatic reset_core();
        @(posedge clk);
        #2 rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #2 rst_n = 1'b1;
        #3;
    endtask

    // sampled mid-cycle before the store retires
    task automatic capture_store();
        if (dmem_wen) begin
            dmem[dmem_addr[7:2]] = dmem_wdata;
            store_addr = dmem_addr;
            store_data = dmem_wdata;
            store_cnt++;
        end
    endtask

    task automatic wait_exit();
        int n;
        n = 0;
        while (!exit_flag && n < TIMEOUT) begin
            capture_store();
            @(posedge clk);
            #5;
            n++;
        end
        if (!exit_flag) begin
            $display("Timeout: exit_o did not rise within %0d cycles", TIMEOUT);
            errors++;
        end
    endtask

    task automatic run_prog(string what, word_t exp);
        if (prog_len > EXIT_IDX) begin
            $display("Program %s runs past the exit address", what);
            errors++;
        end
        reset_core();
        wait_exit();
        check_val("gp_o", what, gp, exp);
    endtask

    task automatic rr_case(logic [6:0] f7, logic [2:0] f3, word_t a, word_t b, word_t exp,
                           string what);
        begin_prog();
        load_const(5'd1, a);
        load_const(5'd2, b);
        emit(enc_r(f7, 5'd2, 5'd1, f3, 5'd3));
        run_prog(what, exp);
    endtask

    task automatic ri_case(logic [2:0] f3, logic [11:0] imm, word_t a, word_t exp, string what);
        begin_prog();
        load_const(5'd1, a);
        emit(enc_i(imm, 5'd1, f3, 5'd3, OP_I));
        run_prog(what, exp);
    endtask

    // taken branch hops over the x3 increment
    task automatic branch_skip(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2);
        emit(enc_b(13'd8, rs2, rs1, f3));
        emit(enc_i(12'd1, 5'd3, 3'b000, 5'd3, OP_I));
    endtask

    task automatic test_reset();
        begin_prog();
        reset_core();
        check_val("imem_addr_o", "reset", imem_addr, 32'h0);
        check_val("exit_o", "reset", word_t'(exit_flag), 32'h0);
        @(posedge clk);
        #5;
        check_val("imem_addr_o", "first fetch", imem_addr, 32'h4);
    endtask

    task automatic test_arith();
        word_t       a;
        word_t       b;
        logic [11:0] imm;
        a   = rand_bits(32);
        b   = rand_bits(32);
        imm = 12'(rand_bits(12));
        rr_case(7'h00, 3'b000, a, b, a + b, "add");
        rr_case(7'h20, 3'b000, a, b, a - b, "sub");
        rr_case(7'h00, 3'b111, a, b, a & b, "and");
        rr_case(7'h00, 3'b110, a, b, a | b, "or");
        rr_case(7'h00, 3'b100, a, b, a ^ b, "xor");
        ri_case(3'b000, imm, a, a + sext12(imm), "addi");
        ri_case(3'b111, imm, a, a & sext12(imm), "andi");
        ri_case(3'b110, imm, a, a | sext12(imm), "ori");
        ri_case(3'b100, imm, a, a ^ sext12(imm), "xori");
        begin_prog();
        load_const(5'd1, a);
        emit(enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd0));   // add x0, x1, x1
        emit(enc_r(7'h00, 5'd1, 5'd0, 3'b110, 5'd3));   // or x3, x0, x1
        run_prog("x0 write", a);
    endtask

    task automatic test_shift_cmp();
        word_t       a;
        word_t       p;
        word_t       b;
        logic [4:0]  sh;
        logic [11:0] imm;
        a   = rand_bits(32) | 32'h8000_0000;    // negative
        p   = rand_bits(32) & 32'h7fff_ffff;
        b   = rand_bits(32);
        sh  = b[4:0];
        imm = 12'(rand_bits(12)) | 12'h800;
        rr_case(7'h00, 3'b001, a, b, a << sh, "sll");
        rr_case(7'h00, 3'b101, a, b, a >> sh, "srl");
        rr_case(7'h20, 3'b101, a, b, word_t'($signed(a) >>> sh), "sra");
        rr_case(7'h00, 3'b010, a, p, {31'b0, $signed(a) < $signed(p)}, "slt");
        rr_case(7'h00, 3'b011, a, p, {31'b0, a < p}, "sltu");
        ri_case(3'b001, {7'h00, sh}, a, a << sh, "slli");
        ri_case(3'b101, {7'h00, sh}, a, a >> sh, "srli");
        ri_case(3'b101, {7'h20, sh}, a, word_t'($signed(a) >>> sh), "srai");
        ri_case(3'b010, imm, p, {31'b0, $signed(p) < $signed(sext12(imm))}, "slti");
        ri_case(3'b011, imm, p, {31'b0, p < sext12(imm)}, "sltiu");
    endtask

    task automatic test_mem();
        word_t       base;
        word_t       data;
        word_t       ea;
        logic [11:0] off;
        base = 32'h80;
        off  = {6'b0, 4'(rand_bits(4)), 2'b00};
        data = rand_bits(32);
        ea   = base + sext12(off);
        begin_prog();
        load_const(5'd1, base);
        load_const(5'd2, data);
        emit(enc_s(off, 5'd2, 5'd1));
        emit(enc_i(off, 5'd1, 3'b010, 5'd3, OP_LOAD));
        run_prog("lw after sw", data);
        check_val("dmem_wen_o", "sw count", word_t'(store_cnt), 32'd1);
        check_val("dmem_addr_o", "sw", store_addr, ea);
        check_val("dmem_wdata_o", "sw", store_data, data);
        check_val("dmem", "sw", dmem[ea[7:2]], data);
        // untouched word still holds its fill value
        begin_prog();
        load_const(5'd1, 32'hc0);
        emit(enc_i(12'h004, 5'd1, 3'b010, 5'd3, OP_LOAD));
        run_prog("lw fill", {16'h00c4, ~16'h00c4});
    endtask

    task automatic test_branch();
        logic [2:0] conds [6];
        word_t      n;
        word_t      p;
        int         not_taken;
        conds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        n     = rand_bits(32) | 32'h8000_0000;
        p     = rand_bits(32) & 32'h7fff_ffff;
        foreach (conds[c]) begin
            begin_prog();
            load_const(5'd1, n);
            emit(enc_i(12'h000, 5'd1, 3'b000, 5'd2, OP_I));   // x2 = x1
            load_const(5'd4, p);
            branch_skip(conds[c], 5'd1, 5'd2);
            branch_skip(conds[c], 5'd1, 5'd4);
            branch_skip(conds[c], 5'd4, 5'd1);
            not_taken = int'(!branch_taken(conds[c], n, n)) + int'(!branch_taken(conds[c], n, p))
                      + int'(!branch_taken(conds[c], p, n));
            run_prog($sformatf("branch funct3 %0d", conds[c]), word_t'(not_taken));
        end
    endtask

    task automatic test_jump();
        logic [19:0] uimm;
        uimm = 20'(rand_bits(20));
        begin_prog();
        emit(NOP);
        emit(enc_j(21'd12, 5'd5));                          // 0x04 jal x5, 0x10
        emit(enc_i(12'd1, 5'd3, 3'b000, 5'd3, OP_I));
        emit(enc_i(12'd1, 5'd3, 3'b000, 5'd3, OP_I));
        emit(enc_r(7'h00, 5'd5, 5'd3, 3'b000, 5'd3));       // 0x10 x3 += x5
        run_prog("jal link", 32'h8);
        begin_prog();
        emit(enc_i(12'h015, 5'd0, 3'b000, 5'd1, OP_I));
        emit(NOP);
        emit(enc_i(12'h004, 5'd1, 3'b000, 5'd6, OP_JALR));  // 0x08 jalr x6, 4(x1)
        for (int i = 0; i < 3; i++) begin
            emit(enc_i(12'd1, 5'd3, 3'b000, 5'd3, OP_I));
        end
        emit(enc_r(7'h00, 5'd6, 5'd3, 3'b000, 5'd3));       // 0x18 x3 += x6
        run_prog("jalr link", 32'hc);
        begin_prog();
        for (int i = 0; i < 3; i++) begin
            emit(NOP);
        end
        emit(enc_u(uimm, 5'd3, OP_AUIPC));                  // at 0x0c
        run_prog("auipc", 32'hc + {uimm, 12'h000});
    endtask

    task automatic test_halt();
        word_t val;
        val = rand_bits(32);
        begin_prog();
        load_const(5'd3, val);
        imem[EXIT_IDX] = enc_i(12'd1, 5'd3, 3'b000, 5'd3, OP_I);   // must never retire
        run_prog("halt", val);
        check_val("imem_addr_o", "exit", imem_addr, EXIT_ADDR);
        repeat (10) begin
            @(posedge clk);
            #5;
            check_val("exit_o", "halt", word_t'(exit_flag), 32'h1);
            check_val("imem_addr_o", "halt", imem_addr, EXIT_ADDR);
            check_val("gp_o", "halt", gp, val);
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        checks     = 0;
        errors     = 0;
        store_addr = '0;
        store_data = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            dmem[i] = {16'(i * 4), ~16'(i * 4)};
        end
        begin_prog();
        test_reset();
        test_arith();
        test_shift_cmp();
        test_mem();
        test_branch();
        test_jump();
        test_halt();
        finish_run();
    end

endmodule

//--- verilog.f
+incdir+.
core_pkg.sv
core_dec_if.sv
inst_decoder.sv
reg_file.sv
alu.sv
branch_unit.sv
retire_unit.sv
core.sv
tb_core.sv
